// File: common/vdp_pkg.sv
// VDP register and CPU port types
package vdp_pkg;

    // display mode as {m1, m2, m3}, taken from r1[4], r1[3] and r0[1]
    typedef enum logic [2:0] {
        graphics1  = 3'b000,
        graphics2  = 3'b001,
        multicolor = 3'b010,
        text       = 3'b100
    } vdp_mode_e;

    // command carried by the second byte of a control write
    typedef enum logic [1:0] {
        cmd_rd_addr = 2'b00,    // set the CPU address and prefetch a byte
        cmd_wr_addr = 2'b01,    // set the CPU address for writing
        cmd_reg_wr  = 2'b10     // write the first byte into a register
    } cpu_cmd_e;

    // decoded register fields, 64 bits
    typedef struct packed {
        vdp_mode_e   mode;
        logic        ie;                // interrupt enable
        logic        blank;             // 1 shows the picture, 0 blanks it (TI naming)
        logic        ssiz;              // sprite size, stored only
        logic        smag;              // sprite magnification, stored only
        logic [3:0]  name_base;         // x 1024
        logic [7:0]  color_base;        // x 64
        logic [2:0]  pattern_base;      // x 2048
        logic [6:0]  sprite_att_base;
        logic [2:0]  sprite_pat_base;
        logic [3:0]  fg_color;
        logic [3:0]  bg_color;
        logic [23:0] spare;             // register bits with no function
    } vdp_regs_t;

    // address load request from the control port to the VRAM, 16 bits
    typedef struct packed {
        logic        load;
        logic [13:0] addr;
        logic        prefetch;          // set for a read address
    } vram_cmd_t;

    // bit 7 marks a register write, otherwise bit 6 picks write or read address
    function automatic cpu_cmd_e decode_cmd(input logic [7:0] b);
        if (b[7])
            return cmd_reg_wr;
        return cpu_cmd_e'({1'b0, b[6]});
    endfunction

endpackage

// File: common/video_pkg.sv
// 640x480 raster timing
package video_pkg;

    // horizontal timing in pixel clocks
    localparam int h_total      = 800;
    localparam int h_visible    = 640;
    localparam int h_sync_start = 656;
    localparam int h_sync_len   = 96;

    // vertical timing in lines
    localparam int v_total      = 525;
    localparam int v_visible    = 480;
    localparam int v_sync_start = 490;
    localparam int v_sync_len   = 2;

    // the 256x192 picture doubled to 512x384 and centred
    localparam int pic_left   = 64;
    localparam int pic_top    = 48;
    localparam int pic_width  = 512;
    localparam int pic_height = 384;

    // one raster position with its flags, 27 bits
    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       hsync;          // active low
        logic       vsync;          // active low
        logic       vid_active;     // inside the picture
        logic       bdr_active;     // visible but outside the picture
        logic       col_last;
        logic       row_last;
        logic       last_pixel;     // last pixel of the frame
    } raster_t;

endpackage

// File: logic/vdp_reg_ifce.sv
// VDP control port and registers
`timescale 1ns/1ns

module vdp_reg_ifce import vdp_pkg::*; (
    input  logic       pxclk,
    input  logic       reset,
    input  logic       ctl_wr,          // mode 1 write strobe
    input  logic       ctl_rd,          // mode 1 read strobe
    input  logic [7:0] din,
    input  logic       last_pixel,
    output vdp_regs_t  regs,
    output vram_cmd_t  vram_cmd,
    output logic [7:0] status
);

    logic [7:0] r [8];          // the eight control registers
    logic [7:0] first_q;        // first byte of a control pair
    logic       second_q;       // next control write is the second byte
    logic       irq_flag;
    cpu_cmd_e   cmd;

    assign cmd = decode_cmd(din);   // only meaningful on the second byte

    //********************************************************************
    // two-byte control protocol
    //********************************************************************

    always_ff @(posedge pxclk) begin
        if (reset) begin
            first_q  <= '0;
            second_q <= 1'b0;
            for (int i = 0; i < 8; i++)
                r[i] <= '0;
        end else if (ctl_wr) begin
            if (!second_q) begin
                first_q  <= din;            // hold it until the command byte arrives
                second_q <= 1'b1;
            end else begin
                second_q <= 1'b0;
                if (cmd == cmd_reg_wr)
                    r[din[2:0]] <= first_q;
            end
        end else if (ctl_rd) begin
            second_q <= 1'b0;               // a status read restarts the byte pair
        end
    end

    // address commands go straight to the VRAM counter on the same edge
    assign vram_cmd.load     = ctl_wr && second_q && (cmd != cmd_reg_wr);
    assign vram_cmd.addr     = {din[5:0], first_q};
    assign vram_cmd.prefetch = (cmd == cmd_rd_addr);

    // end of frame sets the flag, a status read clears it, and a set wins a tie
    always_ff @(posedge pxclk) begin
        if (reset)
            irq_flag <= 1'b0;
        else if (last_pixel)
            irq_flag <= 1'b1;
        else if (ctl_rd)
            irq_flag <= 1'b0;
    end

    assign status = {irq_flag, 7'b0};   // no sprites, so the fifth and collision bits stay 0

    //********************************************************************
    // register field decode
    //********************************************************************

    assign regs.mode            = vdp_mode_e'({r[1][4], r[1][3], r[0][1]});
    assign regs.ie              = r[1][5];
    assign regs.blank           = r[1][6];
    assign regs.ssiz            = r[1][1];
    assign regs.smag            = r[1][0];
    assign regs.name_base       = r[2][3:0];
    assign regs.color_base      = r[3];
    assign regs.pattern_base    = r[4][2:0];
    assign regs.sprite_att_base = r[5][6:0];
    assign regs.sprite_pat_base = r[6][2:0];
    assign regs.fg_color        = r[7][7:4];
    assign regs.bg_color        = r[7][3:0];
    // whatever is left over, kept so that every stored bit is visible
    assign regs.spare = {r[0][7:2], r[0][0], r[1][7], r[1][2], r[2][7:4],
                         r[4][7:3], r[5][7], r[6][7:3]};

endmodule

// File: vram/vram.sv
// VRAM with CPU address counter and read-ahead byte
`timescale 1ns/1ns

module vram import vdp_pkg::*; #(
    parameter int VRAM_SIZE = 16384
) (
    input  logic                         pxclk,
    input  logic                         reset,
    input  vram_cmd_t                    vram_cmd,
    input  logic                         cpu_wr,
    input  logic                         cpu_rd,
    input  logic [7:0]                   din,
    output logic [7:0]                   cpu_dout,
    input  logic [$clog2(VRAM_SIZE)-1:0] dma_addr,
    input  logic                         dma_rd_tick,
    output logic [7:0]                   dma_dout
);

    localparam int AW = $clog2(VRAM_SIZE);

    logic [7:0]    mem [VRAM_SIZE];
    logic [AW-1:0] cpu_addr;    // auto-incrementing CPU pointer
    logic [AW-1:0] rd_addr;
    logic [7:0]    rd_q;        // registered read port
    logic [7:0]    cache_q;     // read-ahead byte handed to the CPU
    logic          pending;     // cache needs a refill from cpu_addr
    logic          fill_q;      // rd_q holds the refill byte this cycle
    logic          fill_go;

    //********************************************************************
    // memory array
    //********************************************************************

    // the one read port goes to the display whenever it asks
    assign rd_addr = dma_rd_tick ? dma_addr : cpu_addr;

    always_ff @(posedge pxclk) begin
        if (cpu_wr)
            mem[cpu_addr] <= din;           // lands on the edge closing the strobe
        rd_q <= mem[rd_addr];
    end

    assign dma_dout = rd_q;     // valid one cycle after dma_rd_tick

    //********************************************************************
    // CPU address and read-ahead
    //********************************************************************

    assign fill_go = pending && !dma_rd_tick;   // port is free for the CPU this cycle

    always_ff @(posedge pxclk) begin
        if (reset) begin
            cpu_addr <= '0;
            pending  <= 1'b0;
            fill_q   <= 1'b0;
        end else begin
            if (vram_cmd.load)
                cpu_addr <= vram_cmd.addr[AW-1:0];     // smaller VRAMs wrap
            else if (cpu_wr || cpu_rd)
                cpu_addr <= cpu_addr + 1'b1;
            // a new request beats the one being issued now
            if ((vram_cmd.load && vram_cmd.prefetch) || cpu_rd)
                pending <= 1'b1;
            else if (fill_go)
                pending <= 1'b0;
            fill_q <= fill_go;
        end
    end

    // the refill byte is taken from the read port one cycle after its read
    always_ff @(posedge pxclk) begin
        if (reset)
            cache_q <= '0;
        else if (fill_q)
            cache_q <= rd_q;
    end

    assign cpu_dout = cache_q;

endmodule

// File: logic/vgasync.sv
// VGA raster counters and windows
`timescale 1ns/1ns

module vgasync import video_pkg::*; (
    input  logic    pxclk,
    input  logic    reset,
    output raster_t raster
);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_end;
    logic       v_end;
    logic       in_pic;
    logic       in_vis;

    assign h_end = (h_cnt == 10'(h_total - 1));
    assign v_end = (v_cnt == 10'(v_total - 1));

    always_ff @(posedge pxclk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_end ? '0 : h_cnt + 1'b1;
            if (h_end)
                v_cnt <= v_end ? '0 : v_cnt + 1'b1;
        end
    end

    // windows seen from the current count
    assign in_vis = (h_cnt < 10'(h_visible)) && (v_cnt < 10'(v_visible));
    assign in_pic = (h_cnt >= 10'(pic_left)) && (h_cnt < 10'(pic_left + pic_width)) &&
                    (v_cnt >= 10'(pic_top))  && (v_cnt < 10'(pic_top + pic_height));

    //********************************************************************
    // registered raster output, one cycle behind the counters
    //********************************************************************

    always_ff @(posedge pxclk) begin
        if (reset) begin
            raster       <= '0;
            raster.hsync <= 1'b1;               // syncs idle high
            raster.vsync <= 1'b1;
        end else begin
            raster.col        <= h_cnt;
            raster.row        <= v_cnt;
            raster.hsync      <= !((h_cnt >= 10'(h_sync_start)) &&
                                   (h_cnt < 10'(h_sync_start + h_sync_len)));
            raster.vsync      <= !((v_cnt >= 10'(v_sync_start)) &&
                                   (v_cnt < 10'(v_sync_start + v_sync_len)));
            raster.vid_active <= in_pic;
            raster.bdr_active <= in_vis && !in_pic;     // frame around the picture
            raster.col_last   <= h_end;
            raster.row_last   <= v_end;
            raster.last_pixel <= h_end && v_end;        // col 799 of row 524
        end
    end

endmodule

// File: render/vdp_fsm.sv
// Graphics I tile fetch and pixel shifter
`timescale 1ns/1ns

module vdp_fsm import vdp_pkg::*, video_pkg::*; #(
    parameter int VRAM_SIZE = 16384
) (
    input  logic                         pxclk,
    input  logic                         reset,
    input  vdp_regs_t                    regs,
    input  raster_t                      raster,
    output logic [$clog2(VRAM_SIZE)-1:0] dma_addr,
    output logic                         dma_rd_tick,
    input  logic [7:0]                   vram_dout,
    output raster_t                      raster_out,
    output logic [3:0]                   pix_color
);

    localparam int AW = $clog2(VRAM_SIZE);
    localparam int DLY = 8;         // raster_out lags raster by this many cycles
    localparam raster_t raster_idle = '{hsync: 1'b1, vsync: 1'b1, default: '0};

    typedef enum logic [2:0] {
        s_idle,
        s_name,
        s_pat,
        s_col,
        s_load
    } fetch_state_e;

    fetch_state_e       state;
    logic               wt_q;           // second cycle of a fetch, data is on vram_dout
    logic [9:0]         fx;             // column relative to the first fetch
    logic [9:0]         y;              // screen line inside the picture
    logic               start;
    logic [4:0]         tcol_q;
    logic [4:0]         trow_q;
    logic [2:0]         line_q;
    logic [7:0]         name_q;
    logic [7:0]         pat_q;
    logic [7:0]         col_q;
    logic [7:0]         pat_next;       // fetched tile waiting for its slot
    logic [7:0]         col_next;
    logic [7:0]         sh;             // pattern shifter, MSB is on screen
    logic [7:0]         cur_col;
    logic [13:0]        addr14;
    logic [3:0]         nib;
    raster_t [DLY-1:0]  pipe;

    // tile k is fetched while fx runs 16k..16k+15 and shown 16 columns later
    assign fx    = raster.col - 10'(pic_left - DLY);
    assign y     = raster.row - 10'(pic_top);
    assign start = (state == s_idle) && (regs.mode == graphics1) &&
                   (fx < 10'(pic_width)) && (fx[3:0] == 4'd0) &&
                   (raster.row >= 10'(pic_top)) && (raster.row < 10'(pic_top + pic_height));

    //********************************************************************
    // fetch sequencer, one strobe then one wait per byte
    //********************************************************************

    always_ff @(posedge pxclk) begin
        if (reset) begin
            state <= s_idle;
            wt_q  <= 1'b0;
        end else begin
            case (state)
                s_idle:  if (start) state <= s_name;
                s_name:  if (wt_q) state <= s_pat;
                s_pat:   if (wt_q) state <= s_col;
                s_col:   if (wt_q) state <= s_load;
                default: state <= s_idle;       // s_load takes one cycle
            endcase
            wt_q <= (state inside {s_name, s_pat, s_col}) && !wt_q;
        end
    end

    // tile position and fetched bytes
    always_ff @(posedge pxclk) begin
        if (start) begin
            tcol_q <= fx[8:4];
            trow_q <= y[8:4];           // 8 picture lines per tile, each line doubled
            line_q <= y[3:1];
        end
        if (wt_q && state == s_name)
            name_q <= vram_dout;
        if (wt_q && state == s_pat)
            pat_q <= vram_dout;
        if (wt_q && state == s_col)
            col_q <= vram_dout;
        if (state == s_load) begin
            pat_next <= pat_q;
            col_next <= col_q;
        end
    end

    always_comb begin
        case (state)
            s_name:  addr14 = {regs.name_base, trow_q, tcol_q};
            s_pat:   addr14 = {regs.pattern_base, name_q, line_q};
            default: addr14 = {regs.color_base, 1'b0, name_q[7:3]};
        endcase
    end

    assign dma_addr    = addr14[AW-1:0];
    assign dma_rd_tick = (state inside {s_name, s_pat, s_col}) && !wt_q;

    //********************************************************************
    // pixel shifter and raster delay
    //********************************************************************

    // one pattern bit covers two screen columns, a new tile loads before each boundary
    always_ff @(posedge pxclk) begin
        if (fx[3:0] == 4'hf) begin
            sh      <= pat_next;
            cur_col <= col_next;
        end else if (fx[0]) begin
            sh <= {sh[6:0], 1'b0};
        end
    end

    assign nib       = sh[7] ? cur_col[7:4] : cur_col[3:0];
    assign pix_color = (nib == 4'd0) ? regs.bg_color : nib;    // 0 is transparent

    always_ff @(posedge pxclk) begin
        if (reset)
            pipe <= {DLY{raster_idle}};
        else
            pipe <= {pipe[DLY-2:0], raster};
    end

    assign raster_out = pipe[DLY-1];

endmodule

// File: logic/vdp99.sv
// TMS9918 style video display processor
`timescale 1ns/1ns

module vdp99 import vdp_pkg::*, video_pkg::*; #(
    parameter int VRAM_SIZE = 16384
) (
    input  logic       pxclk,       // 25 MHz
    input  logic       reset,
    input  logic       wr_tick,
    input  logic       rd_tick,
    input  logic       mode,        // 0 is VRAM data, 1 is control
    input  logic [7:0] din,
    output logic [7:0] dout,        // valid while rd_tick is high
    output logic       irq,
    output logic [3:0] color,
    output logic       hsync,
    output logic       vsync
);

    localparam int AW = $clog2(VRAM_SIZE);

    vdp_regs_t     regs;
    vram_cmd_t     vram_cmd;
    raster_t       raster;
    raster_t       raster_out;
    logic [7:0]    status;
    logic [7:0]    cpu_dout;
    logic [7:0]    vram_dout;
    logic [AW-1:0] dma_addr;
    logic          dma_rd_tick;
    logic [3:0]    pix_color;

    vdp_reg_ifce vdp_reg_ifce_i (
        .pxclk(pxclk), .reset(reset),
        .ctl_wr(wr_tick && mode), .ctl_rd(rd_tick && mode), .din(din),
        .last_pixel(raster.last_pixel),     // undelayed, the flag only needs the frame
        .regs(regs), .vram_cmd(vram_cmd), .status(status)
    );

    vram #(.VRAM_SIZE(VRAM_SIZE)) vram_i (
        .pxclk(pxclk), .reset(reset), .vram_cmd(vram_cmd),
        .cpu_wr(wr_tick && !mode), .cpu_rd(rd_tick && !mode), .din(din),
        .cpu_dout(cpu_dout),
        .dma_addr(dma_addr), .dma_rd_tick(dma_rd_tick), .dma_dout(vram_dout)
    );

    vgasync vgasync_i (.pxclk(pxclk), .reset(reset), .raster(raster));

    vdp_fsm #(.VRAM_SIZE(VRAM_SIZE)) vdp_fsm_i (
        .pxclk(pxclk), .reset(reset), .regs(regs), .raster(raster),
        .dma_addr(dma_addr), .dma_rd_tick(dma_rd_tick), .vram_dout(vram_dout),
        .raster_out(raster_out), .pix_color(pix_color)
    );

    // black outside the visible area and whenever the display is off
    always_comb begin
        color = 4'd0;
        if (regs.blank) begin
            if (raster_out.bdr_active)
                color = regs.bg_color;
            else if (raster_out.vid_active)
                color = pix_color;
        end
    end

    assign hsync = raster_out.hsync;
    assign vsync = raster_out.vsync;
    assign irq   = regs.ie && status[7];
    assign dout  = rd_tick ? (mode ? status : cpu_dout) : 8'h00;

endmodule

// File: dv/vdp99_sva.sv
// VDP bound assertions
`timescale 1ns/1ns

module vdp99_sva import vdp_pkg::*; (
    input logic       pxclk,
    input logic       reset,
    input logic       dma_rd_tick,
    input logic       hsync,
    input logic       vsync,
    input logic       irq,
    input logic [3:0] color,
    input logic       last_pixel,
    input vdp_regs_t  regs
);

    // each fetch is a strobe followed by a wait cycle
    dma_gap: assert property (@(posedge pxclk) disable iff (reset)
        dma_rd_tick |=> !dma_rd_tick)
        else $error("dma strobe high on two cycles in a row");

    // syncs sit outside the visible area
    sync_black: assert property (@(posedge pxclk) disable iff (reset)
        (!hsync || !vsync) |-> (color == 4'd0))
        else $error("colour not black during sync");

    // irq only rises with interrupts on, right after the frame ends or as they switch on
    irq_gate: assert property (@(posedge pxclk) disable iff (reset)
        $rose(irq) |-> regs.ie && ($past(last_pixel) || $rose(regs.ie)))
        else $error("irq rose without interrupt enable or end of frame");

endmodule

bind vdp99 vdp99_sva vdp99_sva_i (
    .pxclk(pxclk), .reset(reset), .dma_rd_tick(dma_rd_tick),
    .hsync(hsync), .vsync(vsync), .irq(irq), .color(color),
    .last_pixel(raster.last_pixel), .regs(regs)
);

// File: dv/vdp99_tb.sv
// VDP testbench
`timescale 1ns/1ns

module vdp99_tb import video_pkg::*; ();

    localparam int op_reg   = 0;    // register write, addr is the index
    localparam int op_waddr = 1;    // set the CPU write address
    localparam int op_wdata = 2;    // VRAM data write
    localparam int op_raddr = 3;    // set the CPU read address
    localparam int op_rdata = 4;    // VRAM data read, checked
    localparam int op_stat  = 5;    // status read, checked
    localparam logic [7:0] pat_row  = 8'hf0;    // every row of pattern 0
    localparam logic [7:0] col_byte = 8'ha3;    // colour entry of names 0..7

    typedef struct {
        string name;
        int    op;
        int    addr;
        int    data;
        int    exp;
    } entry_t;

    logic       pxclk = 1'b0;
    logic       reset;
    logic       wr_tick;
    logic       rd_tick;
    logic       mode;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq;
    logic [3:0] color;
    logic       hsync;
    logic       vsync;

    entry_t     tbl[$];
    int         errors = 0;
    int         checks = 0;
    bit         table_ready = 1'b0;
    longint     wd_cycles;

    vdp99 #(.VRAM_SIZE(16384)) vdp99_i (
        .pxclk(pxclk), .reset(reset), .wr_tick(wr_tick), .rd_tick(rd_tick),
        .mode(mode), .din(din), .dout(dout), .irq(irq), .color(color),
        .hsync(hsync), .vsync(vsync)
    );

    always #5 pxclk = ~pxclk;      // 10 ns period

    // limit set from the table length once it is built
    initial begin
        wait (table_ready);
        #(wd_cycles * 10);
        $display("timeout, the run did not reach its end in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    //********************************************************************
    // CPU port and raster helpers
    //********************************************************************

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic strobe_write(input logic m, input logic [7:0] b);
        @(negedge pxclk);
        mode    = m;
        din     = b;
        wr_tick = 1'b1;
        @(negedge pxclk);
        wr_tick = 1'b0;
    endtask

    task automatic ctl_write(input logic [7:0] b);
        strobe_write(1'b1, b);
    endtask

    task automatic vram_write(input logic [7:0] b);
        strobe_write(1'b0, b);
    endtask

    // dout is sampled mid low phase while the strobe is up, then the port rests
    task automatic cpu_read(input logic m, output logic [7:0] b);
        @(negedge pxclk);
        mode    = m;
        rd_tick = 1'b1;
        #2 b = dout;
        @(negedge pxclk);
        rd_tick = 1'b0;
        repeat (5) @(negedge pxclk);
    endtask

    task automatic set_reg(input int idx, input int val);
        ctl_write(8'(val));
        ctl_write(8'h80 | 8'(idx & 7));
    endtask

    task automatic set_waddr(input int a);
        ctl_write(8'(a));
        ctl_write(8'h40 | 8'((a >> 8) & 8'h3f));
    endtask

    task automatic set_raddr(input int a);
        ctl_write(8'(a));
        ctl_write(8'((a >> 8) & 8'h3f));   // bits 7:6 = 00 asks for a prefetch
        repeat (5) @(negedge pxclk);
    endtask

    task automatic wait_hsync_fall();
        while (!hsync) @(negedge pxclk);
        while (hsync) @(negedge pxclk);
    endtask

    task automatic wait_vsync_fall();
        while (!vsync) @(negedge pxclk);
        while (vsync) @(negedge pxclk);
    endtask

    // vsync falls at row 490, so the k-th hsync fall after it is on row 489 + k
    task automatic goto_line(input int row);
        wait_vsync_fall();
        repeat (row + 35) wait_hsync_fall();   // returns at col 656 of the line before
    endtask

    task automatic add(input string n, input int op, input int a, input int d, input int e);
        tbl.push_back('{n, op, a, d, e});
    endtask

    // name table at 0x400, pattern 0 at 0x0000, colour table at 0x2000
    task automatic load_tiles();
        set_waddr(14'h0400);
        repeat (768) vram_write(8'h00);
        set_waddr(14'h0000);
        repeat (8) vram_write(pat_row);
        set_waddr(14'h2000);
        vram_write(col_byte);
    endtask

    //********************************************************************
    // main sequence
    //********************************************************************

    initial begin
        logic [7:0] got;
        logic [7:0] rt_data [8];
        int         exp_c;
        int         low_cycles;
        void'($urandom(32'h43e3a232));
        reset   = 1'b1;
        wr_tick = 1'b0;
        rd_tick = 1'b0;
        mode    = 1'b0;
        din     = 8'h00;
        repeat (8) @(negedge pxclk);
        reset = 1'b0;

        for (int i = 0; i < 8; i++)
            rt_data[i] = 8'($urandom);
        add("status_after_reset", op_stat, 0, 0, 8'h00);
        add("reg1_display_on", op_reg, 1, 8'h40, 0);
        add("reg2_name_base", op_reg, 2, 8'h01, 0);
        add("reg3_color_base", op_reg, 3, 8'h80, 0);
        add("reg4_pattern_base", op_reg, 4, 8'h00, 0);
        add("reg7_colors", op_reg, 7, 8'h15, 0);    // background colour 5
        add("rt_waddr", op_waddr, 14'h3000, 0, 0);
        for (int i = 0; i < 8; i++)
            add($sformatf("rt_wr_%0d", i), op_wdata, 0, rt_data[i], 0);
        add("rt_raddr", op_raddr, 14'h3000, 0, 0);
        for (int i = 0; i < 8; i++)
            add($sformatf("rt_rd_%0d", i), op_rdata, 0, 0, rt_data[i]);
        wd_cycles   = longint'(3 * h_total * v_total) + longint'(tbl.size() * 20);
        table_ready = 1'b1;

        check("irq_after_reset", 0, irq);
        foreach (tbl[i]) begin
            case (tbl[i].op)
                op_reg:   set_reg(tbl[i].addr, tbl[i].data);
                op_waddr: set_waddr(tbl[i].addr);
                op_wdata: vram_write(8'(tbl[i].data));
                op_raddr: set_raddr(tbl[i].addr);
                op_rdata: begin
                    cpu_read(1'b0, got);
                    check(tbl[i].name, tbl[i].exp, got);
                end
                default: begin
                    cpu_read(1'b1, got);
                    check(tbl[i].name, tbl[i].exp, got);
                end
            endcase
        end

        load_tiles();

        // end of frame interrupt, cleared by a status read
        cpu_read(1'b1, got);                // drop any flag left from earlier frames
        set_reg(1, 8'h60);
        wait_vsync_fall();
        low_cycles = 0;
        while (!vsync) begin                // vsync stays low for whole lines
            low_cycles++;
            @(negedge pxclk);
        end
        check("vsync_width", v_sync_len * h_total, low_cycles);
        while (!irq) @(negedge pxclk);
        cpu_read(1'b1, got);
        check("irq_status", 8'h80, got);
        check("irq_cleared", 0, irq);
        cpu_read(1'b1, got);
        check("irq_status_again", 8'h00, got);

        // border at col 10 and picture from col 64 on row 100
        goto_line(100);
        low_cycles = 0;
        while (!hsync) begin
            low_cycles++;
            @(negedge pxclk);
        end
        check("hsync_width", h_sync_len, low_cycles);
        repeat (h_total - h_sync_start - h_sync_len + 10) @(negedge pxclk);
        check("border_on", 5, color);
        repeat (pic_left - 10) @(negedge pxclk);
        for (int p = 0; p < 32; p++) begin
            exp_c = pat_row[7 - (p % 16) / 2] ? col_byte[7:4] : col_byte[3:0];
            check($sformatf("pixel_%0d", p), exp_c, color);
            @(negedge pxclk);
        end

        // display off, so row 101 is black in the border and the picture
        set_reg(1, 8'h20);
        wait_hsync_fall();
        repeat (h_total - h_sync_start + 10) @(negedge pxclk);
        check("border_off", 0, color);
        repeat (pic_left - 4) @(negedge pxclk);
        check("picture_off", 0, color);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: sim.f
common/vdp_pkg.sv
common/video_pkg.sv
logic/vdp_reg_ifce.sv
vram/vram.sv
logic/vgasync.sv
render/vdp_fsm.sv
logic/vdp99.sv
dv/vdp99_sva.sv
dv/vdp99_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vdp99_tb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
